// ==== hw/muldiv_iter_core.sv ====
// iterative execute core: shift-add multiply and restoring divide
// sharing one 2*WIDTH+1 bit accumulator

`default_nettype none

module muldiv_iter_core #(
  parameter int WIDTH = 32
) (
  input  logic        clk,
  input  logic        reset,
  muldiv_stage_if.dst op,
  muldiv_stage_if.src raw
);

  localparam int CW = $clog2(WIDTH);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } state_t;

  state_t               state;
  logic [CW-1:0]        cnt;
  // upper WIDTH+1 bits hold remainder or partial product
  logic [2*WIDTH:0]     acc;
  // divisor for divide, multiplicand for multiply
  logic [WIDTH-1:0]     dvs;
  muldiv_pkg::op_ctrl_t ctrl_reg;

  logic [2*WIDTH:0]     shifted;
  logic [WIDTH:0]       diff;
  logic [WIDTH:0]       sum;
  logic [2*WIDTH:0]     acc_next;

  // ------------------------------------------------------------------------
  // one iteration step
  // ------------------------------------------------------------------------

  always_comb begin
    shifted = {acc[2*WIDTH-1:0], 1'b0};
    diff    = shifted[2*WIDTH:WIDTH] - {1'b0, dvs};
    sum     = acc[2*WIDTH:WIDTH] + {1'b0, dvs};
    if (ctrl_reg.is_div) begin
      // non-negative difference: keep it and shift in a one
      if (!diff[WIDTH]) begin
        acc_next = {diff, shifted[WIDTH-1:1], 1'b1};
      end else begin
        acc_next = shifted;
      end
    end else begin
      // low bit of multiplier picks add, then shift right
      if (acc[0]) begin
        acc_next = {1'b0, sum, acc[WIDTH-1:1]};
      end else begin
        acc_next = {1'b0, acc[2*WIDTH:1]};
      end
    end
  end

  // fsm and counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (op.val) begin
            state <= CALC;
            cnt   <= '0;
          end
        end
        CALC: begin
          cnt <= cnt + 1'b1;
          if (cnt == CW'(WIDTH - 1)) begin
            state <= DONE;
          end
        end
        default: begin
          if (raw.rdy) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // datapath, loaded on the op_link handshake
  always_ff @(posedge clk) begin
    if (op.val && op.rdy) begin
      acc      <= {{(WIDTH + 1){1'b0}}, op.a};
      dvs      <= op.b;
      ctrl_reg <= op.ctrl;
    end else if (state == CALC) begin
      acc <= acc_next;
    end
  end

  assign op.rdy   = (state == IDLE);
  assign raw.val  = (state == DONE);
  assign raw.ctrl = ctrl_reg;
  assign raw.a    = acc[2*WIDTH-1:WIDTH];
  assign raw.b    = acc[WIDTH-1:0];

endmodule

`default_nettype wire

// ==== hw/muldiv_pkg.sv ====
// function codes and per-operation control struct
// shared by the multiply/divide stages

`default_nettype none

package muldiv_pkg;

  // ------------------------------------------------------------------------
  // function code on the request port
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    // signed multiply with full double-width product
    FN_MUL  = 2'd0,
    // signed divide, remainder high and quotient low
    FN_DIV  = 2'd1,
    // unsigned divide
    FN_DIVU = 2'd2
  } fn_t;

  // ------------------------------------------------------------------------
  // control bits that ride along with each operation
  // ------------------------------------------------------------------------

  typedef struct packed {
    // divide iterations instead of multiply
    logic is_div;
    // negate low half (quotient, or product sign)
    logic neg_lo;
    // negate high half (remainder, or product sign)
    logic neg_hi;
  } op_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/muldiv_req_decode.sv ====
// request stage: registers the request, captures operand signs
// and converts signed operands to magnitudes

`default_nettype none

module muldiv_req_decode #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  muldiv_pkg::fn_t    req_fn,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  muldiv_stage_if.src        op
);

  logic                 slot_val;
  logic                 accept;
  logic                 sign_a;
  logic                 sign_b;
  muldiv_pkg::op_ctrl_t ctrl_next;

  // slot frees up in the same cycle the core takes it
  assign req_rdy = !slot_val || op.rdy;
  assign accept  = req_val && req_rdy;

  // unsigned divide ignores the top bit
  assign sign_a = (req_fn != muldiv_pkg::FN_DIVU) && req_a[WIDTH-1];
  assign sign_b = (req_fn != muldiv_pkg::FN_DIVU) && req_b[WIDTH-1];

  always_comb begin
    ctrl_next.is_div = (req_fn != muldiv_pkg::FN_MUL);
    ctrl_next.neg_lo = sign_a ^ sign_b;
    // remainder follows the dividend, product follows the xor
    ctrl_next.neg_hi = ctrl_next.is_div ? sign_a : (sign_a ^ sign_b);
  end

  // ------------------------------------------------------------------------
  // slot valid flag
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_val <= 1'b0;
    end else if (accept) begin
      slot_val <= 1'b1;
    end else if (op.rdy) begin
      slot_val <= 1'b0;
    end
  end

  // payload, magnitudes via two's complement
  always_ff @(posedge clk) begin
    if (accept) begin
      op.a    <= sign_a ? (~req_a + 1'b1) : req_a;
      op.b    <= sign_b ? (~req_b + 1'b1) : req_b;
      op.ctrl <= ctrl_next;
    end
  end

  assign op.val = slot_val;

endmodule

`default_nettype wire

// ==== hw/muldiv_result.sv ====
// result stage: sign restore of product, quotient and remainder
// plus the response register and handshake

`default_nettype none

module muldiv_result #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  muldiv_stage_if.dst        raw,
  output logic               resp_val,
  input  logic               resp_rdy,
  output logic [2*WIDTH-1:0] resp_result
);

  logic                 out_val;
  logic                 capture;
  logic [2*WIDTH-1:0]   mag;
  logic [2*WIDTH-1:0]   fixed;

  // ------------------------------------------------------------------------
  // sign fix-up
  // ------------------------------------------------------------------------

  always_comb begin
    mag = {raw.a, raw.b};
    if (raw.ctrl.is_div) begin
      // remainder and quotient negated on their own
      fixed[2*WIDTH-1:WIDTH] = raw.ctrl.neg_hi ? -raw.a : raw.a;
      fixed[WIDTH-1:0]       = raw.ctrl.neg_lo ? -raw.b : raw.b;
    end else begin
      // whole product negated, borrow crosses the halves
      fixed = raw.ctrl.neg_lo ? -mag : mag;
    end
  end

  // register is free when empty or draining this cycle
  assign raw.rdy = !out_val || resp_rdy;
  assign capture = raw.val && raw.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (capture) begin
      out_val <= 1'b1;
    end else if (resp_rdy) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      resp_result <= fixed;
    end
  end

  assign resp_val = out_val;

endmodule

`default_nettype wire

// ==== hw/muldiv_stage_if.sv ====
// val/rdy link between muldiv pipeline stages
// carries control struct and two data words

`default_nettype none

interface muldiv_stage_if #(
  parameter int WIDTH = 32
) ();

  // producer has an item
  logic val;
  // consumer can take it this cycle
  logic rdy;

  muldiv_pkg::op_ctrl_t ctrl;

  // operand magnitudes on op_link, high/low result halves on raw_link
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;

  modport src (output val, output ctrl, output a, output b, input rdy);

  modport dst (input val, input ctrl, input a, input b, output rdy);

endinterface

`default_nettype wire

// ==== hw/muldiv_unit.sv ====
// multiply/divide unit top level
// decode, iterative core and result stage joined by two stage links

`default_nettype none

module muldiv_unit #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  muldiv_pkg::fn_t    req_fn,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  output logic               resp_val,
  input  logic               resp_rdy,
  output logic [2*WIDTH-1:0] resp_result
);

  // ------------------------------------------------------------------------
  // stage links
  // ------------------------------------------------------------------------

  // operand magnitudes into the core
  muldiv_stage_if #(.WIDTH(WIDTH)) op_link ();
  // unsigned high/low halves out of the core
  muldiv_stage_if #(.WIDTH(WIDTH)) raw_link ();

  muldiv_req_decode #(.WIDTH(WIDTH)) u_decode (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .op      (op_link)
  );

  muldiv_iter_core #(.WIDTH(WIDTH)) u_core (
    .clk   (clk),
    .reset (reset),
    .op    (op_link),
    .raw   (raw_link)
  );

  muldiv_result #(.WIDTH(WIDTH)) u_result (
    .clk         (clk),
    .reset       (reset),
    .raw         (raw_link),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

// ==== src.f ====
hw/muldiv_pkg.sv
hw/muldiv_stage_if.sv
hw/muldiv_req_decode.sv
hw/muldiv_iter_core.sv
hw/muldiv_result.sv
hw/muldiv_unit.sv
tests/muldiv_tb.sv

// ==== tests/muldiv_tb.sv ====
// testbench for the multiply/divide unit
// directed tests, back-pressure check and a random mix against a reference model

`default_nettype none

module muldiv_tb;

  localparam int WIDTH = 32;
  // about 60 operations at no more than 40 cycles each, plus margin
  localparam int MAX_CYCLES = 4000;

  logic                 clk;
  logic                 reset;
  logic                 req_val;
  logic                 req_rdy;
  muldiv_pkg::fn_t      req_fn;
  logic [WIDTH-1:0]     req_a;
  logic [WIDTH-1:0]     req_b;
  logic                 resp_val;
  logic                 resp_rdy;
  logic [2*WIDTH-1:0]   resp_result;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          tests;
  int          cycles;

  muldiv_unit #(.WIDTH(WIDTH)) DUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #5 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // lcg step, numerical recipes constants
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // expected response: remainder or upper product high, quotient or lower product low
  function automatic logic [63:0] ref_result(muldiv_pkg::fn_t fn, logic [31:0] a,
                                             logic [31:0] b);
    logic        sa;
    logic        sb;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    longint      prod;
    sa = (fn != muldiv_pkg::FN_DIVU) && a[31];
    sb = (fn != muldiv_pkg::FN_DIVU) && b[31];
    ma = sa ? -a : a;
    mb = sb ? -b : b;
    if (fn == muldiv_pkg::FN_MUL) begin
      prod = $signed(a) * $signed(b);
      return prod;
    end
    // divide by zero gives all ones and the dividend magnitude
    if (mb == 32'd0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    // quotient takes the xor of signs, remainder the dividend sign
    if (sa ^ sb) begin
      q = -q;
    end
    if (sa) begin
      r = -r;
    end
    return {r, q};
  endfunction

  task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    if (errors == start_err) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - start_err);
    end
  endtask

  // called and returns one time unit after a rising edge
  task automatic send_request(input muldiv_pkg::fn_t fn, input logic [31:0] a,
                              input logic [31:0] b);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    // req_rdy is registered, so its value now holds for the next edge
    while (!req_rdy) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic do_op(input muldiv_pkg::fn_t fn, input logic [31:0] a, input logic [31:0] b,
                       input bit rand_rdy);
    logic [63:0] exp;
    logic [31:0] r;
    logic        done;
    exp = ref_result(fn, a, b);
    send_request(fn, a, b);
    done = 1'b0;
    while (!done) begin
      if (rand_rdy) begin
        r = next_rand();
        resp_rdy = r[20];
      end else begin
        resp_rdy = 1'b1;
      end
      // both high now means a transfer on the coming edge
      if (resp_val && resp_rdy) begin
        check_value("resp_result", exp, resp_result);
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  function automatic muldiv_pkg::fn_t fn_from(logic [31:0] r);
    case (r % 32'd3)
      32'd0:   return muldiv_pkg::FN_MUL;
      32'd1:   return muldiv_pkg::FN_DIV;
      default: return muldiv_pkg::FN_DIVU;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic divu_directed();
    int start_err;
    start_err = errors;
    do_op(muldiv_pkg::FN_DIVU, 32'd5, 32'd9, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'd12345, 32'd1, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'hffff_ffff, 32'd2, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'd100, 32'd7, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'h8000_0000, 32'd3, 0);
    report_test("unsigned divide", start_err);
  endtask

  task automatic signed_div_signs();
    int start_err;
    start_err = errors;
    do_op(muldiv_pkg::FN_DIV, 32'd7, 32'd2, 0);
    do_op(muldiv_pkg::FN_DIV, -32'd7, 32'd2, 0);
    do_op(muldiv_pkg::FN_DIV, 32'd7, -32'd2, 0);
    do_op(muldiv_pkg::FN_DIV, -32'd7, -32'd2, 0);
    // most negative by minus one wraps back to itself
    do_op(muldiv_pkg::FN_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
    report_test("signed divide signs", start_err);
  endtask

  task automatic signed_mul();
    int start_err;
    start_err = errors;
    do_op(muldiv_pkg::FN_MUL, 32'd3, 32'd5, 0);
    do_op(muldiv_pkg::FN_MUL, -32'd3, 32'd5, 0);
    do_op(muldiv_pkg::FN_MUL, -32'd3, -32'd5, 0);
    do_op(muldiv_pkg::FN_MUL, 32'h7fff_ffff, 32'h7fff_ffff, 0);
    do_op(muldiv_pkg::FN_MUL, 32'h8000_0000, 32'h8000_0000, 0);
    do_op(muldiv_pkg::FN_MUL, 32'h1234_5678, -32'd1, 0);
    report_test("signed multiply", start_err);
  endtask

  task automatic divide_by_zero();
    int start_err;
    start_err = errors;
    do_op(muldiv_pkg::FN_DIV, -32'd100, 32'd0, 0);
    do_op(muldiv_pkg::FN_DIV, 32'd100, 32'd0, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'hffff_0000, 32'd0, 0);
    do_op(muldiv_pkg::FN_DIVU, 32'd0, 32'd0, 0);
    report_test("divide by zero", start_err);
  endtask

  task automatic backpressure_order();
    logic [63:0]     exp_q[$];
    logic [63:0]     exp;
    muldiv_pkg::fn_t fn;
    logic [31:0]     a;
    logic [31:0]     b;
    int              accepted;
    int              idle;
    int              start_err;
    start_err = errors;
    accepted  = 0;
    idle      = 0;
    resp_rdy  = 1'b0;
    // keep issuing until req_rdy stays low longer than one operation
    while (accepted < 8 && idle < 80) begin
      if (req_rdy) begin
        fn = fn_from(accepted);
        a  = next_rand();
        b  = next_rand() >> 20;
        exp_q.push_back(ref_result(fn, a, b));
        send_request(fn, a, b);
        accepted++;
        idle = 0;
      end else begin
        @(posedge clk);
        #1;
        idle++;
      end
    end
    if (accepted < 2 || accepted >= 8) begin
      $display("back-pressure: %0d requests accepted while resp_rdy was held low", accepted);
      errors++;
    end
    check_value("resp_val", 1, resp_val);
    resp_rdy = 1'b1;
    while (exp_q.size() > 0) begin
      if (resp_val) begin
        exp = exp_q.pop_front();
        check_value("resp_result", exp, resp_result);
      end
      @(posedge clk);
      #1;
    end
    report_test("back-pressure and ordering", start_err);
  endtask

  task automatic random_mix();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int          start_err;
    start_err = errors;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      a = next_rand();
      // small divisors now and then so quotients are not mostly zero
      if (r[3:2] == 2'b00) begin
        b = {28'd0, r[31:28]};
      end else begin
        b = next_rand();
      end
      do_op(fn_from(r >> 16), a, b, 1);
    end
    resp_rdy = 1'b1;
    report_test("random mix", start_err);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = muldiv_pkg::FN_MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b1;
    seed     = 32'h8d29_9d9c;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    cycles   = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("req_rdy", 1, req_rdy);
    check_value("resp_val", 0, resp_val);
    divu_directed();
    signed_div_signs();
    signed_mul();
    divide_by_zero();
    backpressure_order();
    random_mix();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
